// ==== packet_parse.f ====
verilog/rx_parse_pkg.sv
verilog/field_sequencer.sv
verilog/ebv_ptr_parser.sv
verilog/handle_matcher.sv
verilog/packet_parse.sv
testbench/packet_parse_assertions.sv
testbench/packet_parse_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the packet parser testbench with verilator

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module packet_parse_tb -f packet_parse.f \
  --Mdir "$build_dir" -o packet_parse_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# keep running past assertion errors so the testbench gives its verdict
"./$build_dir/packet_parse_sim" +verilator+error+limit+1000 > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1

// ==== testbench/packet_parse_assertions.sv ====
// Parser flag assertions
`timescale 1ns/10ps
`default_nettype none

module packet_parse_assertions (
  input wire logic                       bitinclk,
  input wire logic                       reset,
  input wire rx_parse_pkg::packet_type_t packet_type,
  input wire rx_parse_pkg::rx_fields_t   fields,
  input wire logic                       handle_match,
  input wire logic                       write_data_ready
);

  // one failure counter per property
  int   sticky_failures = 0;
  int   ready_failures  = 0;
  int   unkept_failures = 0;
  logic unkept_type;

  // codes the parser does not walk
  assign unkept_type = !(packet_type inside {rx_parse_pkg::cmd_query, rx_parse_pkg::cmd_queryadj,
                                             rx_parse_pkg::cmd_ack, rx_parse_pkg::cmd_reqrn,
                                             rx_parse_pkg::cmd_read, rx_parse_pkg::cmd_write});

  // result flags only drop through reset
  flags_sticky: assert property (@(posedge bitinclk) disable iff (reset)
      !$fell(handle_match) && !$fell(write_data_ready))
    else begin
      $error("result flag fell without reset");
      sticky_failures++;
    end

  ready_only_write: assert property (@(posedge bitinclk) disable iff (reset)
      write_data_ready |-> (packet_type == rx_parse_pkg::cmd_write))
    else begin
      $error("write_data_ready high outside a write");
      ready_failures++;
    end

  unkept_fields_zero: assert property (@(posedge bitinclk) disable iff (reset)
      unkept_type |-> (fields == '0))
    else begin
      $error("fields changed under an unparsed command");
      unkept_failures++;
    end

endmodule

bind packet_parse packet_parse_assertions packet_parse_assertions_i (
  .bitinclk         (bitinclk),
  .reset            (reset),
  .packet_type      (packet_type),
  .fields           (fields),
  .handle_match     (handle_match),
  .write_data_ready (write_data_ready)
);

`default_nettype wire

// ==== testbench/packet_parse_tb.sv ====
// Packet parser testbench
`timescale 1ns/10ps
`default_nettype none

module packet_parse_tb;

  localparam int          clk_period  = 40;
  localparam int          num_packets = 200;
  // a write with two extension bytes takes about 61 cycles
  localparam int          max_cycles  = 80;
  localparam logic [15:0] lfsr_seed   = 16'd31078;

  logic                       bitinclk;
  logic                       reset;
  logic                       bitin;
  rx_parse_pkg::packet_type_t packet_type;
  rx_parse_pkg::handle_t      current_handle;
  rx_parse_pkg::handle_t      current_rn;
  rx_parse_pkg::rx_fields_t   fields;
  logic                       handle_match;
  logic                       write_data_ready;

  // model state for the packet in flight
  logic [15:0]                lfsr_state;
  logic                       stream[$];
  rx_parse_pkg::rx_fields_t   exp_fields;
  logic                       exp_match;
  int                         field_errors;
  int                         flag_errors;

  packet_parse dut_i (
    .reset            (reset),
    .bitinclk         (bitinclk),
    .bitin            (bitin),
    .packet_type      (packet_type),
    .current_handle   (current_handle),
    .current_rn       (current_rn),
    .fields           (fields),
    .handle_match     (handle_match),
    .write_data_ready (write_data_ready)
  );

  always #(clk_period / 2) bitinclk = ~bitinclk;

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0])
      return (state >> 1) ^ 16'hb400;
    else
      return state >> 1;
  endfunction

  // one lfsr step per bit, first bit taken ends up as the msb
  function automatic logic [31:0] take_random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  // random field appended to the bit stream msb first
  function automatic logic [31:0] send_random_field(input int width);
    logic [31:0] value;
    value = take_random_bits(width);
    for (int i = width - 1; i >= 0; i--)
      stream.push_back(value[i]);
    return value;
  endfunction

  // 0 to 2 extension bytes, then the pointer byte with a clear flag
  function automatic logic [rx_parse_pkg::ptr_w-1:0] send_ebv_ptr();
    int ext_bytes;
    ext_bytes = int'(take_random_bits(2) % 3);
    for (int b = 0; b < ext_bytes; b++) begin
      stream.push_back(1'b1);
      void'(send_random_field(rx_parse_pkg::ebv_byte_w - 1));
    end
    stream.push_back(1'b0);
    return rx_parse_pkg::ptr_w'(send_random_field(rx_parse_pkg::ebv_byte_w - 1));
  endfunction

  // trailing handle, sometimes with one bit flipped
  function automatic logic send_handle();
    logic       flip;
    logic [3:0] flip_idx;
    flip     = 1'(take_random_bits(1));
    flip_idx = 4'(take_random_bits(4));
    for (int i = rx_parse_pkg::handle_w - 1; i >= 0; i--)
      stream.push_back(current_handle[i] ^ (flip && i == int'(flip_idx)));
    return ~flip;
  endfunction

  // picks a command and builds its bits and expected results
  task automatic build_packet(output rx_parse_pkg::packet_type_t cmd, output string name);
    logic [2:0]                      pick;
    logic [rx_parse_pkg::data_w-1:0] sent;
    pick           = 3'(take_random_bits(3));
    current_handle = rx_parse_pkg::handle_w'(take_random_bits(rx_parse_pkg::handle_w));
    current_rn     = rx_parse_pkg::handle_w'(take_random_bits(rx_parse_pkg::handle_w));
    exp_fields     = '0;
    exp_match      = 1'b0;
    stream.delete();
    case (pick)
      3'd0: begin
        cmd  = rx_parse_pkg::cmd_query;
        name = "query";
        void'(send_random_field(rx_parse_pkg::query_skip_head));
        exp_fields.sel = rx_parse_pkg::sel_w'(send_random_field(rx_parse_pkg::sel_w));
        void'(send_random_field(rx_parse_pkg::query_skip_mid));
        exp_fields.q = rx_parse_pkg::q_w'(send_random_field(rx_parse_pkg::q_w));
      end
      3'd1: begin
        cmd  = rx_parse_pkg::cmd_queryadj;
        name = "queryadj";
        void'(send_random_field(rx_parse_pkg::queryadj_skip));
        exp_fields.updn = rx_parse_pkg::updn_w'(send_random_field(rx_parse_pkg::updn_w));
      end
      3'd2, 3'd3: begin
        cmd       = (pick == 3'd2) ? rx_parse_pkg::cmd_ack : rx_parse_pkg::cmd_reqrn;
        name      = (pick == 3'd2) ? "ack" : "reqrn";
        exp_match = send_handle();
      end
      3'd4, 3'd5: begin
        cmd  = (pick == 3'd4) ? rx_parse_pkg::cmd_read : rx_parse_pkg::cmd_write;
        name = (pick == 3'd4) ? "read" : "write";
        exp_fields.bank = rx_parse_pkg::bank_w'(send_random_field(rx_parse_pkg::bank_w));
        exp_fields.ptr  = send_ebv_ptr();
        if (pick == 3'd4) begin
          exp_fields.words = rx_parse_pkg::words_w'(send_random_field(rx_parse_pkg::words_w));
        end else begin
          // tag sees the data cover-coded with its rn16
          sent = rx_parse_pkg::data_w'(send_random_field(rx_parse_pkg::data_w));
          exp_fields.write_data = sent ^ current_rn;
        end
        exp_match = send_handle();
      end
      default: begin
        case (take_random_bits(2) % 3)
          0:       cmd = rx_parse_pkg::cmd_queryrep;
          1:       cmd = rx_parse_pkg::cmd_select;
          default: cmd = rx_parse_pkg::cmd_nack;
        endcase
        name = "unkept";
        void'(send_random_field(20));
      end
    endcase
  endtask

  task automatic check_fields(input string name, input rx_parse_pkg::rx_fields_t expected,
                              input rx_parse_pkg::rx_fields_t actual);
    if (actual !== expected) begin
      field_errors++;
      $display("error %s: fields expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      flag_errors++;
      $display("error %s: expected %b actual %b", name, expected, actual);
    end
  endtask

  // failures seen by the bound assertion module
  function automatic int count_assertion_failures();
    return dut_i.packet_parse_assertions_i.sticky_failures
         + dut_i.packet_parse_assertions_i.ready_failures
         + dut_i.packet_parse_assertions_i.unkept_failures;
  endfunction

  initial begin
    rx_parse_pkg::packet_type_t cmd;
    string                      name;
    string                      test_name;
    int                         assert_fails;
    bitinclk       = 1'b0;
    reset          = 1'b1;
    bitin          = 1'b0;
    packet_type    = '0;
    current_handle = '0;
    current_rn     = '0;
    lfsr_state     = lfsr_seed;
    field_errors   = 0;
    flag_errors    = 0;
    repeat (4) @(posedge bitinclk);
    @(negedge bitinclk);
    for (int n = 0; n < num_packets; n++) begin
      // one cycle reset pulse, command word already valid
      reset = 1'b1;
      bitin = 1'b0;
      build_packet(cmd, name);
      packet_type = cmd;
      @(negedge bitinclk);
      reset = 1'b0;
      foreach (stream[i]) begin
        bitin = stream[i];
        @(negedge bitinclk);
      end
      // two idle cycles after the last bit
      bitin = 1'b0;
      repeat (2) @(negedge bitinclk);
      test_name = $sformatf("%s packet %0d", name, n);
      check_fields(test_name, exp_fields, fields);
      check_flag({test_name, " handle_match"}, exp_match, handle_match);
      check_flag({test_name, " write_data_ready"}, cmd == rx_parse_pkg::cmd_write,
                 write_data_ready);
    end
    assert_fails = count_assertion_failures();
    $display("field errors %0d, flag errors %0d, assertion failures %0d",
             field_errors, flag_errors, assert_fails);
    if (field_errors + flag_errors + assert_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // worst case budget for every packet
  initial begin
    #(num_packets * max_cycles * clk_period);
    $display("timeout: the packets did not finish within the watchdog time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/ebv_ptr_parser.sv ====
// EBV word pointer parser
`timescale 1ns/10ps
`default_nettype none

module ebv_ptr_parser (
  input  wire logic                          reset,
  input  wire logic                          bitinclk,
  input  wire logic                          bitin,
  input  wire logic                          ptr_phase,
  output logic [rx_parse_pkg::ptr_w-1:0]     ptr,
  output logic                               ptr_done
);

  // position inside the current ebv byte
  logic [$clog2(rx_parse_pkg::ebv_byte_w)-1:0] byte_count;
  // extension flag was clear, this byte carries the pointer
  logic                                        final_byte;
  logic                                        done;
  logic                                        byte_end;

  assign byte_end = (int'(byte_count) == rx_parse_pkg::ebv_byte_w - 1);

  // high only on the edge that takes the last pointer bit
  assign ptr_done = ptr_phase && !done && final_byte && byte_end;

  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      byte_count <= '0;
      final_byte <= 1'b0;
      done       <= 1'b0;
      ptr        <= '0;
    end else if (ptr_phase && !done) begin
      // counter wraps at the byte boundary
      byte_count <= byte_count + 1'b1;
      if (byte_count == '0) begin
        // first bit set means another byte follows
        final_byte <= ~bitin;
      end else if (final_byte) begin
        // seven bits shift in, top bit stays zero
        ptr <= {ptr[rx_parse_pkg::ptr_w-2:0], bitin};
        if (byte_end)
          done <= 1'b1;
      end
      // extended bytes are simply skipped
    end
  end

endmodule

`default_nettype wire

// ==== verilog/field_sequencer.sv ====
// Command field sequencer
`timescale 1ns/10ps
`default_nettype none

module field_sequencer (
  input  wire logic                      reset,
  input  wire logic                      bitinclk,
  input  wire logic                      bitin,
  input  wire rx_parse_pkg::packet_type_t packet_type,
  input  wire rx_parse_pkg::handle_t      current_rn,
  input  wire logic                      ptr_done,
  output logic                           ptr_phase,
  output logic                           handle_phase,
  output rx_parse_pkg::rx_fields_t       fields_plain,
  output logic                           write_data_ready
);

  // registered phase, valid once the first bit has been taken
  rx_parse_pkg::parse_phase_t phase;
  rx_parse_pkg::parse_phase_t start_phase;
  rx_parse_pkg::parse_phase_t cur_phase;
  rx_parse_pkg::parse_phase_t next_phase;
  logic                                    running;
  logic [rx_parse_pkg::bit_count_w-1:0]    bit_count;
  logic                                    field_last;
  int                                      field_len;
  // write data lands msb first
  logic [$clog2(rx_parse_pkg::data_w)-1:0] data_idx;

  // first field depends only on the command word
  always_comb begin
    case (packet_type)
      rx_parse_pkg::cmd_query,
      rx_parse_pkg::cmd_queryadj: start_phase = rx_parse_pkg::skip_head;
      rx_parse_pkg::cmd_ack,
      rx_parse_pkg::cmd_reqrn:    start_phase = rx_parse_pkg::handle;
      rx_parse_pkg::cmd_read,
      rx_parse_pkg::cmd_write:    start_phase = rx_parse_pkg::bank;
      // anything else carries nothing we parse
      default:                    start_phase = rx_parse_pkg::idle;
    endcase
  end

  // on the first edge after reset the phase comes straight from the command
  assign cur_phase = running ? phase : start_phase;

  // length of the current field and the phase after it
  always_comb begin
    field_len  = 0;
    next_phase = cur_phase;
    case (cur_phase)
      rx_parse_pkg::skip_head: begin
        if (packet_type == rx_parse_pkg::cmd_query) begin
          field_len  = rx_parse_pkg::query_skip_head;
          next_phase = rx_parse_pkg::sel;
        end else begin
          field_len  = rx_parse_pkg::queryadj_skip;
          next_phase = rx_parse_pkg::updn;
        end
      end
      rx_parse_pkg::sel: begin
        field_len  = rx_parse_pkg::sel_w;
        next_phase = rx_parse_pkg::skip_mid;
      end
      rx_parse_pkg::skip_mid: begin
        field_len  = rx_parse_pkg::query_skip_mid;
        next_phase = rx_parse_pkg::q;
      end
      rx_parse_pkg::q: begin
        field_len  = rx_parse_pkg::q_w;
        next_phase = rx_parse_pkg::idle;
      end
      rx_parse_pkg::updn: begin
        field_len  = rx_parse_pkg::updn_w;
        next_phase = rx_parse_pkg::idle;
      end
      rx_parse_pkg::bank: begin
        field_len  = rx_parse_pkg::bank_w;
        next_phase = rx_parse_pkg::ebv_ptr;
      end
      // pointer length is set by the ebv parser
      rx_parse_pkg::ebv_ptr: begin
        next_phase = (packet_type == rx_parse_pkg::cmd_read) ? rx_parse_pkg::words
                                                             : rx_parse_pkg::data;
      end
      rx_parse_pkg::words: begin
        field_len  = rx_parse_pkg::words_w;
        next_phase = rx_parse_pkg::handle;
      end
      rx_parse_pkg::data: begin
        field_len  = rx_parse_pkg::data_w;
        next_phase = rx_parse_pkg::handle;
      end
      rx_parse_pkg::handle: begin
        field_len  = rx_parse_pkg::handle_w;
        next_phase = rx_parse_pkg::idle;
      end
      default: begin
        field_len  = 0;
        next_phase = rx_parse_pkg::idle;
      end
    endcase
  end

  // this bit closes the field
  assign field_last = (cur_phase == rx_parse_pkg::ebv_ptr) ? ptr_done
                                                           : (int'(bit_count) == field_len - 1);

  assign data_idx     = ~bit_count[$clog2(rx_parse_pkg::data_w)-1:0];
  assign ptr_phase    = (cur_phase == rx_parse_pkg::ebv_ptr);
  assign handle_phase = (cur_phase == rx_parse_pkg::handle);

  // phase and bit counter
  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      running   <= 1'b0;
      phase     <= rx_parse_pkg::idle;
      bit_count <= '0;
    end else begin
      running <= 1'b1;
      if (cur_phase != rx_parse_pkg::idle && field_last) begin
        phase     <= next_phase;
        bit_count <= '0;
      end else begin
        phase <= cur_phase;
        // no counting while the pointer parser owns the stream
        if (cur_phase != rx_parse_pkg::idle && cur_phase != rx_parse_pkg::ebv_ptr)
          bit_count <= bit_count + 1'b1;
      end
    end
  end

  // field capture, all msb first
  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      fields_plain     <= '0;
      write_data_ready <= 1'b0;
    end else begin
      case (cur_phase)
        rx_parse_pkg::sel:
          fields_plain.sel <= {fields_plain.sel[rx_parse_pkg::sel_w-2:0], bitin};
        rx_parse_pkg::q:
          fields_plain.q <= {fields_plain.q[rx_parse_pkg::q_w-2:0], bitin};
        rx_parse_pkg::updn:
          fields_plain.updn <= {fields_plain.updn[rx_parse_pkg::updn_w-2:0], bitin};
        rx_parse_pkg::bank:
          fields_plain.bank <= {fields_plain.bank[rx_parse_pkg::bank_w-2:0], bitin};
        rx_parse_pkg::words:
          fields_plain.words <= {fields_plain.words[rx_parse_pkg::words_w-2:0], bitin};
        rx_parse_pkg::data: begin
          // cover-coded against the current rn16
          fields_plain.write_data[data_idx] <= bitin ^ current_rn[data_idx];
          if (field_last)
            write_data_ready <= 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/handle_matcher.sv ====
// Serial handle matcher
`timescale 1ns/10ps
`default_nettype none

module handle_matcher (
  input  wire logic                 reset,
  input  wire logic                 bitinclk,
  input  wire logic                 bitin,
  input  wire logic                 handle_phase,
  input  wire rx_parse_pkg::handle_t current_handle,
  output logic                      handle_match
);

  // handle bit index, counts from the msb
  logic [$clog2(rx_parse_pkg::handle_w)-1:0] bit_idx;
  logic                                      match_failed;
  logic                                      bit_ok;
  logic                                      last_bit;

  // ~bit_idx walks the handle from bit 15 down
  assign bit_ok   = (bitin == current_handle[~bit_idx]);
  assign last_bit = &bit_idx;

  always_ff @(posedge bitinclk or posedge reset) begin
    if (reset) begin
      bit_idx      <= '0;
      match_failed <= 1'b0;
      handle_match <= 1'b0;
    end else if (handle_phase && !match_failed && !handle_match) begin
      bit_idx <= bit_idx + 1'b1;
      if (!bit_ok)
        // one wrong bit fails the whole handle
        match_failed <= 1'b1;
      else if (last_bit)
        handle_match <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/packet_parse.sv ====
// Packet parser top level
`timescale 1ns/10ps
`default_nettype none

module packet_parse (
  input  wire logic                      reset,
  input  wire logic                      bitinclk,
  input  wire logic                      bitin,
  input  wire rx_parse_pkg::packet_type_t packet_type,
  input  wire rx_parse_pkg::handle_t      current_handle,
  input  wire rx_parse_pkg::handle_t      current_rn,
  output rx_parse_pkg::rx_fields_t       fields,
  output logic                           handle_match,
  output logic                           write_data_ready
);

  // sequencer hands the stream to the pointer parser and the matcher
  logic                             ptr_phase;
  logic                             ptr_done;
  logic                             handle_phase;
  logic [rx_parse_pkg::ptr_w-1:0]   ptr;
  rx_parse_pkg::rx_fields_t         fields_plain;

  field_sequencer field_sequencer_i (
    .reset            (reset),
    .bitinclk         (bitinclk),
    .bitin            (bitin),
    .packet_type      (packet_type),
    .current_rn       (current_rn),
    .ptr_done         (ptr_done),
    .ptr_phase        (ptr_phase),
    .handle_phase     (handle_phase),
    .fields_plain     (fields_plain),
    .write_data_ready (write_data_ready)
  );

  ebv_ptr_parser ebv_ptr_parser_i (
    .reset     (reset),
    .bitinclk  (bitinclk),
    .bitin     (bitin),
    .ptr_phase (ptr_phase),
    .ptr       (ptr),
    .ptr_done  (ptr_done)
  );

  handle_matcher handle_matcher_i (
    .reset          (reset),
    .bitinclk       (bitinclk),
    .bitin          (bitin),
    .handle_phase   (handle_phase),
    .current_handle (current_handle),
    .handle_match   (handle_match)
  );

  // pointer comes from its own parser, the rest from the sequencer
  always_comb begin
    fields     = fields_plain;
    fields.ptr = ptr;
  end

endmodule

`default_nettype wire

// ==== verilog/rx_parse_pkg.sv ====
// Receive parser definitions
`default_nettype none

package rx_parse_pkg;

  // field and word widths
  localparam int packet_type_w = 13;
  localparam int handle_w      = 16;
  localparam int q_w           = 4;
  localparam int sel_w         = 2;
  localparam int updn_w        = 3;
  localparam int bank_w        = 2;
  localparam int ptr_w         = 8;
  localparam int words_w       = 8;
  localparam int data_w        = 16;
  localparam int ebv_byte_w    = 8;
  localparam int bit_count_w   = 5;

  // bits skipped ahead of the captured fields
  localparam int query_skip_head = 4;
  localparam int query_skip_mid  = 3;
  localparam int queryadj_skip   = 2;

  // one-hot command word as decoded by the receiver
  typedef logic [packet_type_w-1:0] packet_type_t;
  typedef logic [handle_w-1:0]      handle_t;

  // codes keep their receiver bit positions
  localparam packet_type_t cmd_queryrep = 13'b0000000000001;
  localparam packet_type_t cmd_ack      = 13'b0000000000010;
  localparam packet_type_t cmd_query    = 13'b0000000000100;
  localparam packet_type_t cmd_queryadj = 13'b0000000001000;
  // select and nack carry no fields here
  localparam packet_type_t cmd_select   = 13'b0000000010000;
  localparam packet_type_t cmd_nack     = 13'b0000000100000;
  localparam packet_type_t cmd_reqrn    = 13'b0000001000000;
  localparam packet_type_t cmd_read     = 13'b0000010000000;
  localparam packet_type_t cmd_write    = 13'b0000100000000;

  // every field the parser hands to the tag controller
  typedef struct packed {
    logic [q_w-1:0]     q;
    logic [sel_w-1:0]   sel;
    logic [updn_w-1:0]  updn;
    logic [bank_w-1:0]  bank;
    logic [ptr_w-1:0]   ptr;
    logic [words_w-1:0] words;
    logic [data_w-1:0]  write_data;
  } rx_fields_t;

  // sequencer phases, one per field of the packet
  typedef enum logic [3:0] {
    skip_head,
    sel,
    skip_mid,
    q,
    updn,
    bank,
    ebv_ptr,
    words,
    data,
    handle,
    idle
  } parse_phase_t;

endpackage

`default_nettype wire
